// ==== flist.f ====
+incdir+logic
+incdir+sim
logic/uart_pkg.sv
logic/debug_pkg.sv
logic/baud_rate_generator.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/program_memory.sv
logic/debug_unit.sv
logic/top_arquitectura.sv
sim/tb_top_arquitectura.sv

// ==== logic/baud_rate_generator.sv ====
`timescale 1ns/100ps
`include "mips_defs.svh"

module baud_rate_generator #(
    parameter int BAUD_RATE    = `BAUD_RATE,
    parameter int FREC_CLK_MHZ = `FREC_CLK_MHZ
) (
    input  logic i_clock,
    input  logic i_rst_n,
    output logic o_rate      // One pulse per 1/16 bit.
);

    // Rounded clocks per oversampling tick.
    localparam int DIVISOR = (FREC_CLK_MHZ * 1000000 + 8 * BAUD_RATE) / (16 * BAUD_RATE);
    localparam int CNT_W   = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt    <= '0;
            o_rate <= 1'b0;
        end else if (cnt == CNT_W'(DIVISOR - 1)) begin
            cnt    <= '0;                    // Reload.
            o_rate <= 1'b1;
        end else begin
            cnt    <= cnt + 1'b1;
            o_rate <= 1'b0;
        end
    end

endmodule

// ==== logic/debug_pkg.sv ====
`include "mips_defs.svh"

package debug_pkg;

    typedef logic [`LONG_INSTRUCCION-1:0]         instr_t;  // Instruction word.
    typedef logic [`ADDR_MEM_PROGRAMA_LENGTH-1:0] addr_t;   // Program address.

    // Debug unit sequencing.
    typedef enum logic [2:0] {
        DBG_CMD,        // Waiting for a command byte.
        DBG_RESET,      // Four-phase soft reset of memory.
        DBG_LOAD,       // Collecting the bytes of a word.
        DBG_WRITE,      // One write cycle.
        DBG_COUNT,      // Waiting for the dump length.
        DBG_READ_WAIT,  // Two-cycle memory read.
        DBG_SEND        // Waiting for the transmitter.
    } dbg_state_t;

endpackage

// ==== logic/debug_unit.sv ====
`timescale 1ns/100ps
`include "mips_defs.svh"

module debug_unit (
    input  logic              i_clock,
    input  logic              i_rst_n,
    input  logic              i_rx_done,
    input  uart_pkg::byte_t   i_data_rx,
    input  logic              i_tx_done,
    input  logic              i_soft_reset_ack,
    input  debug_pkg::instr_t i_dato_mem_programa,   // Read data, two cycles late.
    output logic              o_tx_start,
    output uart_pkg::byte_t   o_data_tx,
    output logic              o_soft_reset,
    output logic              o_write_mem_programa,
    output debug_pkg::addr_t  o_addr_mem_programa,
    output debug_pkg::instr_t o_dato_mem_programa,
    output logic              o_enable_mem,
    output logic              o_rsta_mem,
    output logic              o_regcea_mem,
    output logic              o_led                  // Program loaded.
);

    debug_pkg::dbg_state_t state;
    debug_pkg::addr_t      addr_r;
    debug_pkg::instr_t     word_r;      // Assembled or outgoing word.
    logic [1:0]            byte_cnt;    // Byte of word, or read wait.
    uart_pkg::byte_t       dump_left;   // Words still to send. Zero outside a dump.
    logic                  is_halt;

    assign is_halt = (word_r[`LONG_INSTRUCCION-1 -: 6] == `HALT_OPCODE);

    ////////////////////
    // Memory port.
    ////////////////////
    assign o_addr_mem_programa  = addr_r;
    assign o_dato_mem_programa  = word_r;
    assign o_write_mem_programa = (state == debug_pkg::DBG_WRITE);
    assign o_enable_mem         = (state == debug_pkg::DBG_WRITE) ||
                                  (state == debug_pkg::DBG_READ_WAIT);
    assign o_regcea_mem         = (state == debug_pkg::DBG_READ_WAIT);
    assign o_rsta_mem           = (state == debug_pkg::DBG_RESET);   // Blank output reg.

    ////////////////////
    // Sequencer.
    ////////////////////
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= debug_pkg::DBG_CMD;
            addr_r       <= '0;
            word_r       <= '0;
            byte_cnt     <= '0;
            dump_left    <= '0;
            o_tx_start   <= 1'b0;
            o_data_tx    <= '0;
            o_soft_reset <= 1'b0;
            o_led        <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;
            case (state)
                debug_pkg::DBG_CMD: if (i_rx_done) begin
                    addr_r   <= '0;
                    byte_cnt <= '0;
                    if (i_data_rx == `CMD_LOAD) begin
                        o_led        <= 1'b0;
                        o_soft_reset <= 1'b1;          // Request the sweep.
                        state        <= debug_pkg::DBG_RESET;
                    end else if (i_data_rx == `CMD_DUMP) begin
                        state <= debug_pkg::DBG_COUNT;
                    end else begin
                        o_data_tx  <= `RSP_ERROR;      // Unknown command.
                        o_tx_start <= 1'b1;
                        state      <= debug_pkg::DBG_SEND;
                    end
                end
                debug_pkg::DBG_RESET: begin
                    if (o_soft_reset && i_soft_reset_ack)
                        o_soft_reset <= 1'b0;          // Phase three.
                    else if (!o_soft_reset && !i_soft_reset_ack)
                        state <= debug_pkg::DBG_LOAD;  // Handshake closed.
                end
                debug_pkg::DBG_LOAD: if (i_rx_done) begin
                    word_r   <= {word_r[`LONG_INSTRUCCION-9:0], i_data_rx};  // MSB first.
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == 2'd3)
                        state <= debug_pkg::DBG_WRITE;
                end
                debug_pkg::DBG_WRITE: begin
                    addr_r <= addr_r + 1'b1;
                    if (is_halt) begin
                        o_data_tx  <= 8'(addr_r + 1'b1);   // Word count, halt included.
                        o_tx_start <= 1'b1;
                        o_led      <= 1'b1;
                        state      <= debug_pkg::DBG_SEND;
                    end else begin
                        state <= debug_pkg::DBG_LOAD;
                    end
                end
                debug_pkg::DBG_COUNT: if (i_rx_done) begin
                    dump_left <= i_data_rx;
                    state     <= (i_data_rx == '0) ? debug_pkg::DBG_CMD :
                                                     debug_pkg::DBG_READ_WAIT;
                end
                debug_pkg::DBG_READ_WAIT: begin
                    byte_cnt <= byte_cnt + 1'b1;       // Counts read latency here.
                    if (byte_cnt == 2'd2) begin
                        byte_cnt   <= '0;
                        word_r     <= i_dato_mem_programa << 8;
                        o_data_tx  <= i_dato_mem_programa[`LONG_INSTRUCCION-1 -: 8];
                        o_tx_start <= 1'b1;
                        state      <= debug_pkg::DBG_SEND;
                    end
                end
                debug_pkg::DBG_SEND: if (i_tx_done) begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (dump_left == '0) begin
                        state <= debug_pkg::DBG_CMD;   // Single response byte.
                    end else if (byte_cnt != 2'd3) begin
                        word_r     <= word_r << 8;
                        o_data_tx  <= word_r[`LONG_INSTRUCCION-1 -: 8];
                        o_tx_start <= 1'b1;
                    end else begin
                        dump_left <= dump_left - 1'b1;
                        addr_r    <= addr_r + 1'b1;
                        state     <= (dump_left == 8'd1) ? debug_pkg::DBG_CMD :
                                                           debug_pkg::DBG_READ_WAIT;
                    end
                end
                default: state <= debug_pkg::DBG_CMD;
            endcase
        end
    end

    // No program longer than the memory.
    a_addr_wrap : assert property (@(posedge i_clock) disable iff (!i_rst_n)
        (state == debug_pkg::DBG_WRITE && !is_halt) |=> addr_r != '0);

endmodule

// ==== logic/mips_defs.svh ====
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

////////////////////
// UART framing.
////////////////////
`define WIDTH_WORD               8       // Payload bits per frame.
`define CANT_BIT_STOP            2       // Stop bits per frame.
`define FREC_CLK_MHZ             50      // Default clock, MHz.
`define BAUD_RATE                9600    // Default line rate.

////////////////////
// Program memory.
////////////////////
`define LONG_INSTRUCCION         32
`define RAM_DEPTH_PROGRAMA       2048
`define ADDR_MEM_PROGRAMA_LENGTH 11
`define HALT_OPCODE              6'h3F   // Bits 31..26 of the last word.

// Host protocol bytes.
`define CMD_LOAD                 8'h01
`define CMD_DUMP                 8'h02
`define RSP_ERROR                8'hEE

`endif

// ==== logic/program_memory.sv ====
`timescale 1ns/100ps
`include "mips_defs.svh"

module program_memory (
    input  logic              i_clock,
    input  logic              i_rst_n,
    input  debug_pkg::addr_t  i_addr,
    input  debug_pkg::instr_t i_data,
    input  logic              i_wea,         // Write enable.
    input  logic              i_ena,         // Port enable.
    input  logic              i_rsta,        // Clears output reg.
    input  logic              i_regcea,      // Output reg enable.
    input  logic              i_soft_reset,
    output debug_pkg::instr_t o_data,
    output logic              o_reset_ack
);

    debug_pkg::instr_t ram [`RAM_DEPTH_PROGRAMA];
    debug_pkg::addr_t  addr_r;               // Registered read address.
    debug_pkg::addr_t  sweep_addr;
    logic              sweeping;

    ////////////////////
    // Array and read pipeline.
    ////////////////////
    always_ff @(posedge i_clock) begin
        if (sweeping)
            ram[sweep_addr] <= '0;           // One word per cycle.
        else if (i_ena && i_wea)
            ram[i_addr] <= i_data;
        if (i_ena)
            addr_r <= i_addr;
        if (i_rsta)
            o_data <= '0;
        else if (i_regcea)
            o_data <= ram[addr_r];
    end

    // Soft reset sweep and ack.
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sweeping    <= 1'b0;
            sweep_addr  <= '0;
            o_reset_ack <= 1'b0;
        end else if (sweeping) begin
            sweep_addr <= sweep_addr + 1'b1;   // Wraps back to zero.
            if (sweep_addr == '1) begin
                sweeping    <= 1'b0;
                o_reset_ack <= 1'b1;
            end
        end else if (i_soft_reset && !o_reset_ack) begin
            sweeping <= 1'b1;
        end else if (!i_soft_reset) begin
            o_reset_ack <= 1'b0;               // Phase four.
        end
    end

    // Debug unit holds off writes until the ack.
    a_no_write_sweep : assert property (@(posedge i_clock) disable iff (!i_rst_n)
        sweeping |-> !i_wea);

endmodule

// ==== logic/top_arquitectura.sv ====
`timescale 1ns/100ps
`include "mips_defs.svh"

module top_arquitectura #(
    parameter int BAUD_RATE    = `BAUD_RATE,
    parameter int FREC_CLK_MHZ = `FREC_CLK_MHZ
) (
    input  logic i_clock,
    input  logic i_rst_n,
    input  logic uart_txd_in,     // From host.
    output logic uart_rxd_out,    // To host.
    output logic o_led
);

    logic              rate;
    logic              rx_done;
    uart_pkg::byte_t   data_rx;
    logic              tx_start;
    logic              tx_done;
    uart_pkg::byte_t   data_tx;
    logic              soft_reset;
    logic              soft_reset_ack;
    logic              wea;
    logic              ena;
    logic              rsta;
    logic              regcea;
    debug_pkg::addr_t  addr;
    debug_pkg::instr_t dato_in;
    debug_pkg::instr_t dato_out;

    baud_rate_generator #(.BAUD_RATE(BAUD_RATE), .FREC_CLK_MHZ(FREC_CLK_MHZ)) u_baud (
        .i_clock(i_clock), .i_rst_n(i_rst_n), .o_rate(rate));

    uart_rx u_rx (
        .i_clock(i_clock), .i_rst_n(i_rst_n), .i_rate(rate), .i_bit_rx(uart_txd_in),
        .o_rx_done(rx_done), .o_data_out(data_rx));

    uart_tx u_tx (
        .i_clock(i_clock), .i_rst_n(i_rst_n), .i_rate(rate), .i_tx_start(tx_start),
        .i_data_in(data_tx), .o_bit_tx(uart_rxd_out), .o_tx_done(tx_done));

    debug_unit u_debug (
        .i_clock(i_clock), .i_rst_n(i_rst_n), .i_rx_done(rx_done), .i_data_rx(data_rx),
        .i_tx_done(tx_done), .i_soft_reset_ack(soft_reset_ack),
        .i_dato_mem_programa(dato_out), .o_tx_start(tx_start), .o_data_tx(data_tx),
        .o_soft_reset(soft_reset), .o_write_mem_programa(wea),
        .o_addr_mem_programa(addr), .o_dato_mem_programa(dato_in), .o_enable_mem(ena),
        .o_rsta_mem(rsta), .o_regcea_mem(regcea), .o_led(o_led));

    program_memory u_mem (
        .i_clock(i_clock), .i_rst_n(i_rst_n), .i_addr(addr), .i_data(dato_in),
        .i_wea(wea), .i_ena(ena), .i_rsta(rsta), .i_regcea(regcea),
        .i_soft_reset(soft_reset), .o_data(dato_out), .o_reset_ack(soft_reset_ack));

endmodule

// ==== logic/uart_pkg.sv ====
`include "mips_defs.svh"

package uart_pkg;

    typedef logic [`WIDTH_WORD-1:0] byte_t;   // One UART payload.

    // Receiver frame position.
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    // Transmitter frame position.
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

// ==== logic/uart_rx.sv ====
`timescale 1ns/100ps
`include "mips_defs.svh"

module uart_rx (
    input  logic            i_clock,
    input  logic            i_rst_n,
    input  logic            i_rate,       // 16x tick.
    input  logic            i_bit_rx,     // Line from host.
    output logic            o_rx_done,    // One-cycle byte strobe.
    output uart_pkg::byte_t o_data_out
);

    uart_pkg::rx_state_t state;
    logic [1:0] sync_r;                   // Metastability guard.
    logic [3:0] tick_cnt;
    logic [2:0] bit_cnt;                  // Data or stop bit index.
    logic       stop_ok;                  // Stop bits seen high so far.
    logic       rx_bit;

    assign rx_bit = sync_r[1];

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_r     <= 2'b11;          // Idle line is high.
            state      <= uart_pkg::RX_IDLE;
            tick_cnt   <= '0;
            bit_cnt    <= '0;
            stop_ok    <= 1'b1;
            o_rx_done  <= 1'b0;
            o_data_out <= '0;
        end else begin
            sync_r    <= {sync_r[0], i_bit_rx};
            o_rx_done <= 1'b0;
            case (state)
                uart_pkg::RX_IDLE: begin
                    if (!rx_bit) begin    // Falling edge.
                        tick_cnt <= '0;
                        state    <= uart_pkg::RX_START;
                    end
                end
                uart_pkg::RX_START: if (i_rate) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == 4'd7) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        // Line back high at mid-bit is a glitch.
                        state    <= rx_bit ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end
                end
                uart_pkg::RX_DATA: if (i_rate) begin
                    tick_cnt <= tick_cnt + 1'b1;  // Wraps every bit.
                    if (tick_cnt == 4'd15) begin
                        o_data_out <= {rx_bit, o_data_out[`WIDTH_WORD-1:1]};  // LSB first.
                        bit_cnt    <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'(`WIDTH_WORD - 1)) begin
                            bit_cnt <= '0;
                            stop_ok <= 1'b1;
                            state   <= uart_pkg::RX_STOP;
                        end
                    end
                end
                uart_pkg::RX_STOP: if (i_rate) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == 4'd15) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        stop_ok <= stop_ok & rx_bit;
                        if (bit_cnt == 3'(`CANT_BIT_STOP - 1)) begin
                            o_rx_done <= stop_ok & rx_bit;   // Bad framing drops it.
                            state     <= uart_pkg::RX_IDLE;
                        end
                    end
                end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

    // A byte strobe is a single cycle.
    a_done_pulse : assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_rx_done |=> !o_rx_done);

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/100ps
`include "mips_defs.svh"

module uart_tx (
    input  logic            i_clock,
    input  logic            i_rst_n,
    input  logic            i_rate,       // 16x tick.
    input  logic            i_tx_start,   // Latch i_data_in and go.
    input  uart_pkg::byte_t i_data_in,
    output logic            o_bit_tx,     // Line to host.
    output logic            o_tx_done     // Frame finished.
);

    uart_pkg::tx_state_t state;
    uart_pkg::byte_t     shift_r;
    logic [3:0] tick_cnt;
    logic [2:0] bit_cnt;

    // Line level follows the frame position.
    assign o_bit_tx = (state == uart_pkg::TX_START) ? 1'b0 :
                      (state == uart_pkg::TX_DATA)  ? shift_r[0] : 1'b1;

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= uart_pkg::TX_IDLE;
            shift_r   <= '0;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            o_tx_done <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            case (state)
                uart_pkg::TX_IDLE: begin
                    if (i_tx_start) begin
                        shift_r  <= i_data_in;
                        tick_cnt <= '0;
                        state    <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: if (i_rate) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == 4'd15) begin
                        bit_cnt <= '0;
                        state   <= uart_pkg::TX_DATA;
                    end
                end
                uart_pkg::TX_DATA: if (i_rate) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == 4'd15) begin
                        shift_r <= shift_r >> 1;           // Next bit, LSB first.
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'(`WIDTH_WORD - 1)) begin
                            bit_cnt <= '0;
                            state   <= uart_pkg::TX_STOP;
                        end
                    end
                end
                uart_pkg::TX_STOP: if (i_rate) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == 4'd15) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'(`CANT_BIT_STOP - 1)) begin
                            o_tx_done <= 1'b1;
                            state     <= uart_pkg::TX_IDLE;
                        end
                    end
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

    // The debug unit waits for o_tx_done before the next byte.
    a_start_idle : assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_tx_start |-> state == uart_pkg::TX_IDLE);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f flist.f --top-module tb_top_arquitectura -o tb_top_arquitectura
./obj_dir/tb_top_arquitectura

// ==== sim/tb_uart_tasks.svh ====
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

////////////////////
// Host side of the UART.
////////////////////

// Drives one frame, LSB first. Caller sits on a falling edge.
task automatic send_frame(input uart_pkg::byte_t data, input logic first_stop);
    int i;
    uart_txd_in = 1'b0;                            // Start bit.
    repeat (BIT_CLKS) @(negedge i_clock);
    for (i = 0; i < `WIDTH_WORD; i++) begin
        uart_txd_in = data[i];
        repeat (BIT_CLKS) @(negedge i_clock);
    end
    uart_txd_in = first_stop;                      // Low here breaks the framing.
    repeat (BIT_CLKS) @(negedge i_clock);
    uart_txd_in = 1'b1;                            // Second stop bit.
    repeat (BIT_CLKS) @(negedge i_clock);
endtask

// Captures one frame from the DUT.
// Returns in the middle of the last stop bit.
task automatic receive_frame(output uart_pkg::byte_t data);
    int wait_cnt;
    int i;
    wait_cnt = 0;
    data     = '0;
    while (uart_rxd_out !== 1'b0) begin          // Hunt for the start edge.
        @(negedge i_clock);
        wait_cnt++;
        if (wait_cnt > START_TIMEOUT)
            end_with_failure($sformatf("Timed out at %0t waiting for a start bit", $time));
    end
    repeat (BIT_CLKS / 2) @(negedge i_clock);      // Middle of start bit.
    assert (uart_rxd_out === 1'b0) else
        end_with_failure($sformatf("Start bit from the DUT too short at %0t", $time));
    for (i = 0; i < `WIDTH_WORD; i++) begin
        repeat (BIT_CLKS) @(negedge i_clock);
        data[i] = uart_rxd_out;                    // LSB first.
    end
    for (i = 0; i < `CANT_BIT_STOP; i++) begin
        repeat (BIT_CLKS) @(negedge i_clock);
        assert (uart_rxd_out === 1'b1) else
            end_with_failure($sformatf("Stop bit %0d from the DUT low at %0t", i, $time));
    end
endtask

`endif

// ==== sim/tb_top_arquitectura.sv ====
`timescale 1ns/100ps
`include "mips_defs.svh"

module tb_top_arquitectura;

    localparam int CLK_MHZ       = 50;
    localparam int BAUD          = 781250;
    localparam int BIT_CLKS      = 64;                 // Divisor of 4 times 16 ticks per bit.
    localparam int FRAME_CLKS    = BIT_CLKS * (1 + `WIDTH_WORD + `CANT_BIT_STOP);
    localparam int START_TIMEOUT = 3 * FRAME_CLKS;
    localparam int SWEEP_TIMEOUT = 2 * `RAM_DEPTH_PROGRAMA + 100;
    localparam int ACK_TIMEOUT   = 20;                 // Phase four is a cycle or two.
    localparam int QUIET_CLKS    = 2 * FRAME_CLKS;

    logic i_clock;
    logic i_rst_n;
    logic uart_txd_in;                                 // Host to DUT.
    logic uart_rxd_out;                                // DUT to host.
    logic o_led;

    integer seed = 32'h85e9;
    logic [`LONG_INSTRUCCION-1:0] program_words [$];   // Last loaded program.

    top_arquitectura #(.BAUD_RATE(BAUD), .FREC_CLK_MHZ(CLK_MHZ)) u_dut (
        .i_clock(i_clock), .i_rst_n(i_rst_n), .uart_txd_in(uart_txd_in),
        .uart_rxd_out(uart_rxd_out), .o_led(o_led));

    initial begin
        i_clock = 1'b0;
        forever #10 i_clock = ~i_clock;                // 20 ns period.
    end

    task automatic end_with_failure(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp) else
            end_with_failure($sformatf("mismatch at %0t: %s, got 0x%0h, expected 0x%0h",
                                       $time, what, got, exp));
    endtask

    `include "tb_uart_tasks.svh"

    // Random words with the opcode kept off halt except in the last.
    task automatic make_program(input int n_words);
        logic [`LONG_INSTRUCCION-1:0] w;
        int i;
        program_words.delete();
        for (i = 0; i < n_words; i++) begin
            w = $random(seed);
            if (i == n_words - 1)
                w[31 -: 6] = `HALT_OPCODE;
            else if (w[31 -: 6] == `HALT_OPCODE)
                w[31 -: 6] = 6'h00;
            program_words.push_back(w);
        end
    endtask

    // Four-phase clear as seen from outside.
    task automatic wait_soft_reset();
        int cnt;
        cnt = 0;
        while (u_dut.soft_reset_ack !== 1'b1) begin
            @(negedge i_clock);
            cnt++;
            if (cnt > SWEEP_TIMEOUT)
                end_with_failure("Memory clear was never acknowledged");
        end
        cnt = 0;
        while (u_dut.soft_reset_ack !== 1'b0) begin
            @(negedge i_clock);
            cnt++;
            if (cnt > ACK_TIMEOUT)
                end_with_failure("Memory clear acknowledge never dropped");
        end
    endtask

    ////////////////////
    // Directed tests.
    ////////////////////

    task automatic check_idle();
        int n;
        for (n = 0; n < 200; n++) begin
            @(negedge i_clock);
            check_value(32'(uart_rxd_out), 32'd1, "uart_rxd_out while idle");
            check_value(32'(o_led), 32'd0, "o_led while idle");
        end
    endtask

    task automatic load_program();
        uart_pkg::byte_t resp;
        logic [`LONG_INSTRUCCION-1:0] word;
        int w;
        int b;
        resp = '0;
        send_frame(`CMD_LOAD, 1'b1);
        wait_soft_reset();
        check_value(32'(o_led), 32'd0, "o_led after CMD_LOAD");
        for (w = 0; w < program_words.size(); w++) begin
            word = program_words[w];
            for (b = 3; b >= 0; b--) begin             // MSB first.
                if (w == program_words.size() - 1 && b == 0) begin
                    fork                               // Count byte trails the halt word.
                        send_frame(word[8*b +: 8], 1'b1);
                        receive_frame(resp);
                    join
                end else begin
                    send_frame(word[8*b +: 8], 1'b1);
                end
            end
        end
        check_value(32'(resp), 32'(program_words.size() % 256), "load word count");
        check_value(32'(o_led), 32'd1, "o_led after halt word");
    endtask

    task automatic dump_and_check(input int n_words);
        uart_pkg::byte_t got;
        logic [`LONG_INSTRUCCION-1:0] exp;
        int w;
        int b;
        send_frame(`CMD_DUMP, 1'b1);
        for (w = 0; w < n_words; w++) begin
            exp = (w < program_words.size()) ? program_words[w] : '0;  // Cleared words.
            for (b = 3; b >= 0; b--) begin
                if (w == 0 && b == 3) begin
                    fork                               // Reply starts mid count frame.
                        send_frame(8'(n_words), 1'b1);
                        receive_frame(got);
                    join
                end else begin
                    receive_frame(got);
                end
                check_value(32'(got), 32'(exp[8*b +: 8]),
                            $sformatf("dump word %0d byte %0d", w, 3 - b));
            end
        end
    endtask

    task automatic check_bad_frame();
        uart_pkg::byte_t got;
        int n;
        send_frame(`CMD_DUMP, 1'b0);                   // Dropped by the receiver.
        fork
            send_frame(8'h07, 1'b1);
            receive_frame(got);
        join
        check_value(32'(got), 32'(`RSP_ERROR), "unknown command response");
        for (n = 0; n < QUIET_CLKS; n++) begin         // Nothing else follows.
            @(negedge i_clock);
            check_value(32'(uart_rxd_out), 32'd1, "line after error response");
        end
    endtask

    initial begin
        i_rst_n     = 1'b0;
        uart_txd_in = 1'b1;                            // Idle line.
        repeat (5) @(posedge i_clock);
        @(negedge i_clock);
        i_rst_n = 1'b1;
        check_idle();
        make_program(5);
        load_program();
        dump_and_check(5);
        make_program(2);
        load_program();
        dump_and_check(5);
        check_bad_frame();
        $display("Testbench passed");
        $finish;
    end

endmodule
